//--- Bender.yml
package:
  name: rv_decode

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/decode_pkg.sv
      - source/imm_gen.sv
      - ctrl_decode/ctrl_decode.sv
      - source/id_ex_stage.sv
      - source/rv_decode_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/tb_rv_decode.sv

//--- common/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Datapath and field widths
`define XLEN        32
`define REG_ADDR_W  5
`define CSR_ADDR_W  12

// Trap cause CSR written on ECALL
`define CSR_ECALL_ADDR 12'h342

// RV32I major opcodes
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_SYSTEM  7'b1110011

// funct7 variants
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000  // SUB and SRA/SRAI

`endif

//--- common/decode_pkg.sv
`include "decode_params.svh"

package decode_pkg;

  // ALU operation or branch comparison for the execute stage
  typedef enum logic [4:0] {
    ALU_X     = 5'd0,
    ALU_ADD   = 5'd1,
    ALU_SUB   = 5'd2,
    ALU_AND   = 5'd3,
    ALU_OR    = 5'd4,
    ALU_XOR   = 5'd5,
    ALU_SLL   = 5'd6,
    ALU_SRL   = 5'd7,
    ALU_SRA   = 5'd8,
    ALU_SLT   = 5'd9,
    ALU_SLTU  = 5'd10,
    BR_BEQ    = 5'd11,
    BR_BNE    = 5'd12,
    BR_BLT    = 5'd13,
    BR_BGE    = 5'd14,
    BR_BLTU   = 5'd15,
    BR_BGEU   = 5'd16,
    ALU_JAL   = 5'd17,
    ALU_JALR  = 5'd18,
    ALU_COPY1 = 5'd19   // Pass op1 through for CSR ops
  } exe_fun_e;

  typedef enum logic [1:0] {
    OP1_RS1 = 2'd0,
    OP1_PC  = 2'd1,
    OP1_X   = 2'd2,  // Zero
    OP1_IMZ = 2'd3
  } op1_sel_e;

  typedef enum logic [2:0] {
    OP2_X   = 3'd0,  // Zero
    OP2_RS2 = 3'd1,
    OP2_IMI = 3'd2,
    OP2_IMS = 3'd3,
    OP2_IMJ = 3'd4,
    OP2_IMU = 3'd5
  } op2_sel_e;

  typedef enum logic [2:0] {
    WB_X   = 3'd0,
    WB_ALU = 3'd1,
    WB_MEM = 3'd2,
    WB_PC  = 3'd3,   // Link address
    WB_CSR = 3'd4
  } wb_sel_e;

  typedef enum logic [2:0] {
    CSR_X = 3'd0,
    CSR_W = 3'd1,
    CSR_S = 3'd2,
    CSR_C = 3'd3,
    CSR_E = 3'd4     // Environment call
  } csr_cmd_e;

  // All immediate formats, already extended to XLEN
  typedef struct packed {
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_z;
  } imm_set_t;

  typedef struct packed {
    exe_fun_e               exe_fun;
    op1_sel_e               op1_sel;
    op2_sel_e               op2_sel;
    logic                   mem_wen;
    logic                   rf_wen;
    wb_sel_e                wb_sel;
    csr_cmd_e               csr_cmd;
    logic [`REG_ADDR_W-1:0] wb_addr;
  } ctrl_t;

  // ID/EX pipeline register contents
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
    logic [`XLEN-1:0]       br_offset;
    logic [`REG_ADDR_W-1:0] wb_addr;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    exe_fun_e               exe_fun;
    logic                   mem_wen;
    logic                   rf_wen;
    wb_sel_e                wb_sel;
    csr_cmd_e               csr_cmd;
  } dec_out_t;

endpackage

//--- ctrl_decode/ctrl_decode.sv
`include "decode_params.svh"

module ctrl_decode import decode_pkg::*; (
  input  logic [`XLEN-1:0] inst_i,
  output ctrl_t            ctrl_o
);

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [`REG_ADDR_W-1:0] rd;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rd     = inst_i[11:7];

  // One row of the decode table
  function automatic ctrl_t ctrl_word(exe_fun_e fun, op1_sel_e s1, op2_sel_e s2,
                                      logic mw, logic rw, wb_sel_e wb, csr_cmd_e cmd);
    ctrl_t c;
    c.exe_fun = fun;
    c.op1_sel = s1;
    c.op2_sel = s2;
    c.mem_wen = mw;
    c.rf_wen  = rw;
    c.wb_sel  = wb;
    c.csr_cmd = cmd;
    c.wb_addr = '0;
    return c;
  endfunction

  always_comb begin
    // Unsupported encodings fall through with this word
    ctrl_o = ctrl_word(ALU_X, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);

    case (opcode)
      `OPC_LOAD: begin
        if (funct3 == 3'b010) begin  // LW only
          ctrl_o = ctrl_word(ALU_ADD, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_MEM, CSR_X);
        end
      end
      `OPC_STORE: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin  // SB SH SW
          ctrl_o = ctrl_word(ALU_ADD, OP1_RS1, OP2_IMS, 1'b1, 1'b0, WB_X, CSR_X);
        end
      end
      `OPC_OP_IMM: begin
        case (funct3)
          3'b000: ctrl_o = ctrl_word(ALU_ADD, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_ALU, CSR_X);
          3'b010: ctrl_o = ctrl_word(ALU_SLT, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_ALU, CSR_X);
          3'b011: ctrl_o = ctrl_word(ALU_SLTU, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_ALU, CSR_X);
          3'b100: ctrl_o = ctrl_word(ALU_XOR, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_ALU, CSR_X);
          3'b110: ctrl_o = ctrl_word(ALU_OR, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_ALU, CSR_X);
          3'b111: ctrl_o = ctrl_word(ALU_AND, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_ALU, CSR_X);
          3'b001: begin
            if (funct7 == `F7_BASE) begin  // SLLI
              ctrl_o = ctrl_word(ALU_SLL, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_ALU, CSR_X);
            end
          end
          3'b101: begin
            if (funct7 == `F7_BASE) begin
              ctrl_o = ctrl_word(ALU_SRL, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_ALU, CSR_X);
            end else if (funct7 == `F7_ALT) begin
              ctrl_o = ctrl_word(ALU_SRA, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_ALU, CSR_X);
            end
          end
          default: ;
        endcase
      end
      `OPC_OP: begin
        if (funct7 == `F7_BASE) begin
          case (funct3)
            3'b000: ctrl_o = ctrl_word(ALU_ADD, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
            3'b001: ctrl_o = ctrl_word(ALU_SLL, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
            3'b010: ctrl_o = ctrl_word(ALU_SLT, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
            3'b011: ctrl_o = ctrl_word(ALU_SLTU, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
            3'b100: ctrl_o = ctrl_word(ALU_XOR, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
            3'b101: ctrl_o = ctrl_word(ALU_SRL, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
            3'b110: ctrl_o = ctrl_word(ALU_OR, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
            default: ctrl_o = ctrl_word(ALU_AND, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
          endcase
        end else if (funct7 == `F7_ALT) begin
          case (funct3)
            3'b000: ctrl_o = ctrl_word(ALU_SUB, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
            3'b101: ctrl_o = ctrl_word(ALU_SRA, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
            default: ;
          endcase
        end
      end
      `OPC_BRANCH: begin
        case (funct3)
          3'b000: ctrl_o = ctrl_word(BR_BEQ, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);
          3'b001: ctrl_o = ctrl_word(BR_BNE, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);
          3'b100: ctrl_o = ctrl_word(BR_BLT, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);
          3'b101: ctrl_o = ctrl_word(BR_BGE, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);
          3'b110: ctrl_o = ctrl_word(BR_BLTU, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);
          3'b111: ctrl_o = ctrl_word(BR_BGEU, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);
          default: ;
        endcase
      end
      `OPC_JAL: ctrl_o = ctrl_word(ALU_JAL, OP1_PC, OP2_IMJ, 1'b0, 1'b1, WB_PC, CSR_X);
      `OPC_JALR: begin
        if (funct3 == 3'b000) begin
          ctrl_o = ctrl_word(ALU_JALR, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_PC, CSR_X);
        end
      end
      `OPC_LUI: ctrl_o = ctrl_word(ALU_ADD, OP1_X, OP2_IMU, 1'b0, 1'b1, WB_ALU, CSR_X);
      `OPC_AUIPC: ctrl_o = ctrl_word(ALU_ADD, OP1_PC, OP2_IMU, 1'b0, 1'b1, WB_ALU, CSR_X);
      `OPC_SYSTEM: begin
        case (funct3)
          3'b001: ctrl_o = ctrl_word(ALU_COPY1, OP1_RS1, OP2_X, 1'b0, 1'b1, WB_CSR, CSR_W);
          3'b010: ctrl_o = ctrl_word(ALU_COPY1, OP1_RS1, OP2_X, 1'b0, 1'b1, WB_CSR, CSR_S);
          3'b011: ctrl_o = ctrl_word(ALU_COPY1, OP1_RS1, OP2_X, 1'b0, 1'b1, WB_CSR, CSR_C);
          3'b101: ctrl_o = ctrl_word(ALU_COPY1, OP1_IMZ, OP2_X, 1'b0, 1'b1, WB_CSR, CSR_W);
          3'b110: ctrl_o = ctrl_word(ALU_COPY1, OP1_IMZ, OP2_X, 1'b0, 1'b1, WB_CSR, CSR_S);
          3'b111: ctrl_o = ctrl_word(ALU_COPY1, OP1_IMZ, OP2_X, 1'b0, 1'b1, WB_CSR, CSR_C);
          default: begin
            // ECALL is the only all-zero upper encoding
            if (inst_i[31:8] == 24'h0) begin
              ctrl_o = ctrl_word(ALU_X, OP1_X, OP2_X, 1'b0, 1'b0, WB_X, CSR_E);
            end
          end
        endcase
      end
      default: ;
    endcase

    ctrl_o.wb_addr = rd;
  end

  // No table row both stores and writes back
  a_no_dual_write: assert final (!(ctrl_o.mem_wen && ctrl_o.rf_wen))
    else $error("ctrl_decode: mem_wen and rf_wen both set for %h", inst_i);

endmodule

//--- flist.f
+incdir+common
common/decode_pkg.sv
source/imm_gen.sv
ctrl_decode/ctrl_decode.sv
source/id_ex_stage.sv
source/rv_decode_top.sv
verification/tb_rv_decode.sv

//--- source/id_ex_stage.sv
`include "decode_params.svh"

module id_ex_stage import decode_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  input  logic [`XLEN-1:0] pc_i,
  input  logic [`XLEN-1:0] rs1_data_i,
  input  logic [`XLEN-1:0] rs2_data_i,
  input  ctrl_t            ctrl_i,
  input  imm_set_t         imm_i,
  output logic             dec_valid_o,
  output dec_out_t         dec_o
);

  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  dec_out_t         dec_d;

  always_comb begin
    case (ctrl_i.op1_sel)
      OP1_RS1: op1 = rs1_data_i;
      OP1_PC:  op1 = pc_i;
      OP1_IMZ: op1 = imm_i.imm_z;
      default: op1 = '0;
    endcase
  end

  always_comb begin
    case (ctrl_i.op2_sel)
      OP2_RS2: op2 = rs2_data_i;
      OP2_IMI: op2 = imm_i.imm_i;
      OP2_IMS: op2 = imm_i.imm_s;
      OP2_IMJ: op2 = imm_i.imm_j;
      OP2_IMU: op2 = imm_i.imm_u;
      default: op2 = '0;
    endcase
  end

  always_comb begin
    dec_d.pc        = pc_i;
    dec_d.op1       = op1;
    dec_d.op2       = op2;
    dec_d.br_offset = imm_i.imm_b;
    dec_d.wb_addr   = ctrl_i.wb_addr;
    dec_d.csr_addr  = (ctrl_i.csr_cmd == CSR_E) ? `CSR_ECALL_ADDR
                                                : imm_i.imm_i[`CSR_ADDR_W-1:0];
    dec_d.exe_fun   = ctrl_i.exe_fun;
    dec_d.mem_wen   = ctrl_i.mem_wen;
    dec_d.rf_wen    = ctrl_i.rf_wen;
    dec_d.wb_sel    = ctrl_i.wb_sel;
    dec_d.csr_cmd   = ctrl_i.csr_cmd;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dec_valid_o   <= 1'b0;
      dec_o.rf_wen  <= 1'b0;
      dec_o.mem_wen <= 1'b0;
      dec_o.exe_fun <= ALU_X;
      dec_o.wb_sel  <= WB_X;
      dec_o.csr_cmd <= CSR_X;
    end else begin
      dec_valid_o <= valid_i;
      if (valid_i) dec_o <= dec_d;  // Hold between strobes
    end
  end

  a_rf_wen_has_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_o.rf_wen |-> dec_o.wb_sel != WB_X);

endmodule

//--- source/imm_gen.sv
`include "decode_params.svh"

module imm_gen import decode_pkg::*; (
  input  logic [`XLEN-1:0] inst_i,
  output imm_set_t         imm_o
);

  logic        sign;
  logic [11:0] raw_i;
  logic [11:0] raw_s;
  logic [12:0] raw_b;
  logic [19:0] raw_u;
  logic [20:0] raw_j;
  logic [4:0]  raw_z;

  assign sign  = inst_i[31];
  assign raw_i = inst_i[31:20];
  assign raw_s = {inst_i[31:25], inst_i[11:7]};
  assign raw_b = {inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign raw_u = inst_i[31:12];
  assign raw_j = {inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign raw_z = inst_i[19:15];  // rs1 field as uimm

  always_comb begin
    imm_o.imm_i = {{(`XLEN-12){sign}}, raw_i};
    imm_o.imm_s = {{(`XLEN-12){sign}}, raw_s};
    imm_o.imm_b = {{(`XLEN-13){sign}}, raw_b};
    imm_o.imm_u = {raw_u, {(`XLEN-20){1'b0}}};
    imm_o.imm_j = {{(`XLEN-21){sign}}, raw_j};
    imm_o.imm_z = {{(`XLEN-5){1'b0}}, raw_z};  // Zero extended
  end

endmodule

//--- source/rv_decode_top.sv
`include "decode_params.svh"

module rv_decode_top import decode_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             inst_valid_i,
  input  logic [`XLEN-1:0] inst_i,
  input  logic [`XLEN-1:0] pc_i,
  input  logic [`XLEN-1:0] rs1_data_i,
  input  logic [`XLEN-1:0] rs2_data_i,
  output logic             dec_valid_o,
  output dec_out_t         dec_o
);

  imm_set_t imm;
  ctrl_t    ctrl;

  imm_gen i_imm_gen (
    .inst_i (inst_i),
    .imm_o  (imm)
  );

  // Control table lookup
  ctrl_decode i_ctrl_decode (
    .inst_i (inst_i),
    .ctrl_o (ctrl)
  );

  id_ex_stage i_id_ex_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (inst_valid_i),
    .pc_i        (pc_i),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .ctrl_i      (ctrl),
    .imm_i       (imm),
    .dec_valid_o (dec_valid_o),
    .dec_o       (dec_o)
  );

endmodule

//--- verification/tb_rv_decode.sv
`include "decode_params.svh"

module tb_rv_decode import decode_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int MAX_WAIT   = 10;

  typedef struct packed {
    logic [`XLEN-1:0] inst;
    exe_fun_e         fun;
    op1_sel_e         op1;
    op2_sel_e         op2;
    logic             mem_wen;
    logic             rf_wen;
    wb_sel_e          wb;
    csr_cmd_e         cmd;
  } vec_t;

  logic             clk_i;
  logic             rst_n_i;
  logic             inst_valid_i;
  logic [`XLEN-1:0] inst_i;
  logic [`XLEN-1:0] pc_i;
  logic [`XLEN-1:0] rs1_data_i;
  logic [`XLEN-1:0] rs2_data_i;
  logic             dec_valid_o;
  dec_out_t         dec_o;

  vec_t  vecs[$];
  string names[$];
  int    errors;
  int    checks;

  rv_decode_top i_rv_decode_top (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .dec_valid_o  (dec_valid_o),
    .dec_o        (dec_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic add_vec(string name, logic [`XLEN-1:0] inst, exe_fun_e fun,
                         op1_sel_e o1, op2_sel_e o2, logic mw, logic rw,
                         wb_sel_e wb, csr_cmd_e cmd);
    vec_t v;
    v.inst    = inst;
    v.fun     = fun;
    v.op1     = o1;
    v.op2     = o2;
    v.mem_wen = mw;
    v.rf_wen  = rw;
    v.wb      = wb;
    v.cmd     = cmd;
    vecs.push_back(v);
    names.push_back(name);
  endtask

  // Immediates rebuilt from the ISA bit layout
  function automatic logic [31:0] imm_i_of(logic [31:0] inst);
    logic [31:0] v;
    v = $signed(inst) >>> 20;
    return v;
  endfunction

  function automatic logic [31:0] imm_s_of(logic [31:0] inst);
    logic [31:0] hi;
    hi = $signed(inst) >>> 25;
    return (hi << 5) | {27'b0, inst[11:7]};
  endfunction

  function automatic logic [31:0] imm_b_of(logic [31:0] inst);
    logic [31:0] sx;
    sx = $signed(inst) >>> 31;  // All ones when negative
    return (sx << 12) | ({31'b0, inst[7]} << 11) | ({26'b0, inst[30:25]} << 5)
           | ({28'b0, inst[11:8]} << 1);
  endfunction

  function automatic logic [31:0] imm_j_of(logic [31:0] inst);
    logic [31:0] sx;
    sx = $signed(inst) >>> 31;
    return (sx << 20) | ({24'b0, inst[19:12]} << 12) | ({31'b0, inst[20]} << 11)
           | ({22'b0, inst[30:21]} << 1);
  endfunction

  function automatic logic [31:0] expect_op1(vec_t v, logic [31:0] pc, logic [31:0] rs1);
    case (v.op1)
      OP1_RS1: return rs1;
      OP1_PC:  return pc;
      OP1_IMZ: return {27'b0, v.inst[19:15]};
      default: return '0;
    endcase
  endfunction

  function automatic logic [31:0] expect_op2(vec_t v, logic [31:0] rs2);
    case (v.op2)
      OP2_RS2: return rs2;
      OP2_IMI: return imm_i_of(v.inst);
      OP2_IMS: return imm_s_of(v.inst);
      OP2_IMJ: return imm_j_of(v.inst);
      OP2_IMU: return v.inst & 32'hFFFF_F000;
      default: return '0;
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_valid(logic exp);
    checks++;
    assert (dec_valid_o === exp) else begin
      $display("mismatch at %0t: dec_valid_o expected %b, got %b", $time, exp, dec_valid_o);
      errors++;
    end
  endtask

  task automatic check_output(int idx, logic [31:0] pc, logic [31:0] rs1, logic [31:0] rs2);
    vec_t        v;
    logic [31:0] csr_exp;
    string       n;
    v       = vecs[idx];
    n       = names[idx];
    csr_exp = (v.cmd == CSR_E) ? `CSR_ECALL_ADDR : {20'b0, v.inst[31:20]};
    check_value({n, " dec_o.pc"}, pc, dec_o.pc);
    check_value({n, " dec_o.op1"}, expect_op1(v, pc, rs1), dec_o.op1);
    check_value({n, " dec_o.op2"}, expect_op2(v, rs2), dec_o.op2);
    check_value({n, " dec_o.br_offset"}, imm_b_of(v.inst), dec_o.br_offset);
    check_value({n, " dec_o.wb_addr"}, {27'b0, v.inst[11:7]}, {27'b0, dec_o.wb_addr});
    check_value({n, " dec_o.csr_addr"}, csr_exp, {20'b0, dec_o.csr_addr});
    check_value({n, " dec_o.exe_fun"}, {27'b0, v.fun}, {27'b0, dec_o.exe_fun});
    check_value({n, " dec_o.mem_wen"}, {31'b0, v.mem_wen}, {31'b0, dec_o.mem_wen});
    check_value({n, " dec_o.rf_wen"}, {31'b0, v.rf_wen}, {31'b0, dec_o.rf_wen});
    check_value({n, " dec_o.wb_sel"}, {29'b0, v.wb}, {29'b0, dec_o.wb_sel});
    check_value({n, " dec_o.csr_cmd"}, {29'b0, v.cmd}, {29'b0, dec_o.csr_cmd});
  endtask

  task automatic drive(logic valid, logic [31:0] inst, logic [31:0] pc,
                       logic [31:0] rs1, logic [31:0] rs2);
    inst_valid_i <= valid;
    inst_i       <= inst;
    pc_i         <= pc;
    rs1_data_i   <= rs1;
    rs2_data_i   <= rs2;
  endtask

  task automatic wait_valid(output int waited);
    waited = 0;
    @(negedge clk_i);
    while (dec_valid_o !== 1'b1 && waited < MAX_WAIT) begin
      @(negedge clk_i);
      waited++;
    end
    checks++;
    assert (dec_valid_o === 1'b1) else begin
      $display("dec_valid_o did not rise within %0d cycles of a strobe", MAX_WAIT);
      errors++;
    end
  endtask

  task automatic apply_single(int idx);
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    int          waited;
    pc  = $urandom & 32'hFFFF_FFFC;
    rs1 = $urandom;
    rs2 = $urandom;
    @(posedge clk_i);
    drive(1'b1, vecs[idx].inst, pc, rs1, rs2);
    @(posedge clk_i);
    drive(1'b0, $urandom, $urandom, $urandom, $urandom);  // Idle garbage
    wait_valid(waited);
    checks++;
    assert (waited == 0) else begin
      $display("dec_valid_o for %s came %0d cycles late", names[idx], waited);
      errors++;
    end
    check_output(idx, pc, rs1, rs2);
    @(negedge clk_i);
    check_valid(1'b0);
    check_output(idx, pc, rs1, rs2);  // Output must hold
  endtask

  task automatic apply_pair(int a, int b);
    logic [31:0] pc_a;
    logic [31:0] pc_b;
    logic [31:0] rs_a;
    logic [31:0] rs_b;
    pc_a = $urandom & 32'hFFFF_FFFC;
    pc_b = pc_a + 4;
    rs_a = $urandom;
    rs_b = $urandom;
    @(posedge clk_i);
    drive(1'b1, vecs[a].inst, pc_a, rs_a, rs_b);
    @(posedge clk_i);
    drive(1'b1, vecs[b].inst, pc_b, rs_b, rs_a);
    @(negedge clk_i);
    check_valid(1'b1);
    check_output(a, pc_a, rs_a, rs_b);
    @(posedge clk_i);
    drive(1'b0, '0, '0, '0, '0);
    @(negedge clk_i);
    check_valid(1'b1);
    check_output(b, pc_b, rs_b, rs_a);
    @(negedge clk_i);
    check_valid(1'b0);
  endtask

  initial begin
    int seed;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    rs1_data_i   = '0;
    rs2_data_i   = '0;
    errors       = 0;
    checks       = 0;
    seed         = $urandom(32'h6edd);

    add_vec("ADD", 32'h002081B3, ALU_ADD, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
    add_vec("SUB", 32'h407302B3, ALU_SUB, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
    add_vec("SLT", 32'h0020A233, ALU_SLT, OP1_RS1, OP2_RS2, 1'b0, 1'b1, WB_ALU, CSR_X);
    add_vec("SRAI", 32'h4033D313, ALU_SRA, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_ALU, CSR_X);
    add_vec("ANDI", 32'hFF04F413, ALU_AND, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_ALU, CSR_X);
    add_vec("LW", 32'h00812503, ALU_ADD, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_MEM, CSR_X);
    add_vec("SW", 32'hFEB12E23, ALU_ADD, OP1_RS1, OP2_IMS, 1'b1, 1'b0, WB_X, CSR_X);
    add_vec("BEQ", 32'h00208863, BR_BEQ, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);
    add_vec("BGEU", 32'hFE41FCE3, BR_BGEU, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);
    add_vec("JAL", 32'h001000EF, ALU_JAL, OP1_PC, OP2_IMJ, 1'b0, 1'b1, WB_PC, CSR_X);
    add_vec("JAL back", 32'hFFDFF06F, ALU_JAL, OP1_PC, OP2_IMJ, 1'b0, 1'b1, WB_PC, CSR_X);
    add_vec("JALR", 32'hFF4280E7, ALU_JALR, OP1_RS1, OP2_IMI, 1'b0, 1'b1, WB_PC, CSR_X);
    add_vec("LUI", 32'hABCDE3B7, ALU_ADD, OP1_X, OP2_IMU, 1'b0, 1'b1, WB_ALU, CSR_X);
    add_vec("AUIPC", 32'h12345417, ALU_ADD, OP1_PC, OP2_IMU, 1'b0, 1'b1, WB_ALU, CSR_X);
    add_vec("CSRRW", 32'h30509173, ALU_COPY1, OP1_RS1, OP2_X, 1'b0, 1'b1, WB_CSR, CSR_W);
    add_vec("CSRRSI", 32'h3002E1F3, ALU_COPY1, OP1_IMZ, OP2_X, 1'b0, 1'b1, WB_CSR, CSR_S);
    add_vec("ECALL", 32'h00000073, ALU_X, OP1_X, OP2_X, 1'b0, 1'b0, WB_X, CSR_E);
    // Unsupported encodings
    add_vec("LB", 32'h00010083, ALU_X, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);
    add_vec("OP f7", 32'h022081B3, ALU_X, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);
    add_vec("bad opc", 32'h1234507F, ALU_X, OP1_RS1, OP2_RS2, 1'b0, 1'b0, WB_X, CSR_X);

    for (int i = 0; i < 5; i++) begin
      @(posedge clk_i);
      if (i == 4) rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_valid(1'b0);
    end
    repeat (2) begin
      @(negedge clk_i);
      check_valid(1'b0);
    end

    // Control fields cleared by reset
    check_value("reset dec_o.exe_fun", {27'b0, ALU_X}, {27'b0, dec_o.exe_fun});
    check_value("reset dec_o.mem_wen", 32'd0, {31'b0, dec_o.mem_wen});
    check_value("reset dec_o.rf_wen", 32'd0, {31'b0, dec_o.rf_wen});
    check_value("reset dec_o.wb_sel", {29'b0, WB_X}, {29'b0, dec_o.wb_sel});
    check_value("reset dec_o.csr_cmd", {29'b0, CSR_X}, {29'b0, dec_o.csr_cmd});

    for (int i = 0; i < vecs.size(); i++) apply_single(i);
    apply_pair(0, 6);   // ADD then SW
    apply_pair(16, 9);  // ECALL then JAL

    $display("tb_rv_decode: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
